// File: files.f
+incdir+rtl
rtl/zxuno_pkg.sv
rtl/zxuno_reg_if.sv
rtl/zxuno_port_fsm.sv
rtl/raster_timer.sv
rtl/zxuno_regs.sv
rtl/zxuno_top.sv
verification/tb_zxuno_top.sv

// File: Makefile
SRCS := $(filter %.sv,$(shell cat files.f)) rtl/zxuno_params.svh

.PHONY: all run clean

all: obj_dir/Vtb_zxuno_top

obj_dir/Vtb_zxuno_top: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_zxuno_top -f files.f

run: obj_dir/Vtb_zxuno_top
	./obj_dir/Vtb_zxuno_top

clean:
	rm -rf obj_dir

// File: verification/tb_zxuno_top.sv
`timescale 1ns/1ps
`include "zxuno_params.svh"

module tb_zxuno_top;

   localparam int frame_clks  = `H_TOTAL * `V_TOTAL;
   localparam int n_random    = 400;
   localparam int n_directed  = 80;
   localparam int cycle_limit = 4 * frame_clks + 5 * (n_random + n_directed) + 2000;

   logic        clk;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  cpudout;
   logic [7:0]  cpudin;
   logic        int_n;
   logic [7:0]  devopt_pins;

   // Register model
   logic [7:0]  m_addr;
   logic [7:0]  m_scratch;
   logic [7:0]  m_devopt;
   logic [7:0]  m_rline;
   logic [2:0]  m_rctrl;
   int          m_id_idx;
   string       id_text = `COREID_TEXT;
   int          cycles = 0;

   zxuno_top dut_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .a                (a),
      .iorq_n           (iorq_n),
      .rd_n             (rd_n),
      .wr_n             (wr_n),
      .cpudout          (cpudout),
      .cpudin           (cpudin),
      .int_n            (int_n),
      .disable_ay       (devopt_pins[0]),
      .disable_turboay  (devopt_pins[1]),
      .disable_7ffd     (devopt_pins[2]),
      .disable_1ffd     (devopt_pins[3]),
      .disable_romsel7f (devopt_pins[4]),
      .disable_romsel1f (devopt_pins[5]),
      .enable_timexmmu  (devopt_pins[6]),
      .disable_spisd    (devopt_pins[7])
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Run did not finish within %0d clock cycles", cycle_limit);
         $display("Testbench failed");
         $fatal(1, "Timeout");
      end
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------
   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Testbench failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      assert (got == exp) else begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Testbench failed");
         $fatal(1, "Count mismatch");
      end
   endtask

   task automatic check_devopt_pins();
      int i;
      for (i = 0; i < 8; i++) begin
         check_byte($sformatf("device option pin %0d", i),
                    {7'b0, devopt_pins[i]}, {7'b0, m_devopt[i]});
      end
   endtask

   // ----------------------------------------------------------
   // Bus cycles and model
   // ----------------------------------------------------------
   // Three clocks of stable access, one idle clock before the next
   task automatic bus_access(input logic [15:0] port, input logic is_wr,
                             input logic [7:0] data, output logic [7:0] rdata);
      @(posedge clk);
      #2;
      a       = port;
      cpudout = data;
      iorq_n  = 1'b0;
      rd_n    = is_wr;
      wr_n    = !is_wr;
      // Sampled before the strobe can move the core-id index
      @(negedge clk);
      rdata = cpudin;
      repeat (3) @(posedge clk);
      #2;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
   endtask

   task automatic write_port(input logic [15:0] port, input logic [7:0] data);
      logic [7:0] ignored;
      bus_access(port, 1'b1, data, ignored);
      if (port == `ZXUNO_ADDR_PORT) begin
         m_addr   = data;
         m_id_idx = 0;
      end else if (port == `ZXUNO_DATA_PORT) begin
         case (m_addr)
            `REG_SCRATCH:    m_scratch = data;
            `REG_RASTERLINE: m_rline   = data;
            `REG_RASTERCTRL: m_rctrl   = data[2:0];
            `REG_DEVOPTIONS: m_devopt  = data;
            default: ;
         endcase
      end
   endtask

   function automatic logic [7:0] expected_read(input logic [15:0] port);
      if (port == `ZXUNO_ADDR_PORT) return m_addr;
      if (port != `ZXUNO_DATA_PORT) return 8'hFF;
      case (m_addr)
         `REG_SCRATCH:    return m_scratch;
         `REG_RASTERLINE: return m_rline;
         `REG_RASTERCTRL: return {5'b00000, m_rctrl};
         `REG_DEVOPTIONS: return m_devopt;
         `REG_COREID:     return 8'(id_text[m_id_idx]);
         default:         return 8'h00;
      endcase
   endfunction

   task automatic read_port(input logic [15:0] port);
      logic [7:0] got;
      logic [7:0] exp;
      exp = expected_read(port);
      bus_access(port, 1'b0, 8'h00, got);
      // Bit 7 is the live raster flag, checked in the interrupt frames
      if (port == `ZXUNO_DATA_PORT && m_addr == `REG_RASTERCTRL) got[7] = 1'b0;
      check_byte("cpudin", got, exp);
      if (port == `ZXUNO_DATA_PORT && m_addr == `REG_COREID) begin
         m_id_idx = (m_id_idx + 1) % `COREID_LEN;
      end
   endtask

   function automatic logic [7:0] random_reg();
      case ($urandom_range(0, 6))
         0:       return `REG_SCRATCH;
         1:       return `REG_RASTERLINE;
         2:       return `REG_RASTERCTRL;
         3:       return `REG_DEVOPTIONS;
         4:       return `REG_COREID;
         default: return 8'($urandom);
      endcase
   endfunction

   function automatic logic [15:0] other_port();
      logic [15:0] p;
      p = 16'($urandom);
      while (p == `ZXUNO_ADDR_PORT || p == `ZXUNO_DATA_PORT) p = 16'($urandom);
      return p;
   endfunction

   task automatic random_mix(input int n);
      int k;
      logic [7:0] data;
      for (k = 0; k < n; k++) begin
         data = 8'($urandom);
         case ($urandom_range(0, 7))
            0:       write_port(`ZXUNO_ADDR_PORT, random_reg());
            1, 2:    write_port(`ZXUNO_DATA_PORT, data);
            3, 4:    read_port(`ZXUNO_DATA_PORT);
            5:       read_port(`ZXUNO_ADDR_PORT);
            6:       read_port(other_port());
            default: write_port(other_port(), data);
         endcase
         check_devopt_pins();
      end
   endtask

   // One full frame with a data-port read held open on the control register
   task automatic check_int_frame(input int exp_low, input int exp_raster);
      int n;
      int low_cnt;
      int raster_cnt;
      low_cnt    = 0;
      raster_cnt = 0;
      @(posedge clk);
      #2;
      a      = `ZXUNO_DATA_PORT;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      for (n = 0; n < frame_clks; n++) begin
         @(negedge clk);
         if (!int_n) begin
            low_cnt++;
            if (cpudin[7]) raster_cnt++;
         end
      end
      @(posedge clk);
      #2;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      check_count("int_n low cycles", low_cnt, exp_low);
      check_count("rasterctrl bit 7 high cycles", raster_cnt, exp_raster);
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      logic [8:0] line;
      int         k;
      void'($urandom(58348));
      a         = 16'h0000;
      iorq_n    = 1'b1;
      rd_n      = 1'b1;
      wr_n      = 1'b1;
      cpudout   = 8'h00;
      rst_n     = 1'b0;
      m_addr    = 8'h00;
      m_scratch = 8'h00;
      m_devopt  = 8'h00;
      m_rline   = 8'h00;
      m_rctrl   = 3'b000;
      m_id_idx  = 0;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_byte("int_n", {7'b0, int_n}, 8'h01);
      check_devopt_pins();

      // Scratch and address readback
      write_port(`ZXUNO_ADDR_PORT, `REG_SCRATCH);
      for (k = 0; k < 4; k++) begin
         write_port(`ZXUNO_DATA_PORT, 8'($urandom));
         read_port(`ZXUNO_DATA_PORT);
         read_port(`ZXUNO_ADDR_PORT);
      end

      // Device options
      write_port(`ZXUNO_ADDR_PORT, `REG_DEVOPTIONS);
      for (k = 0; k < 4; k++) begin
         write_port(`ZXUNO_DATA_PORT, 8'($urandom));
         check_devopt_pins();
         read_port(`ZXUNO_DATA_PORT);
      end

      // Core id wraps, address write restarts it
      write_port(`ZXUNO_ADDR_PORT, `REG_COREID);
      for (k = 0; k < 2 * `COREID_LEN + 3; k++) read_port(`ZXUNO_DATA_PORT);
      write_port(`ZXUNO_ADDR_PORT, `REG_COREID);
      for (k = 0; k < 4; k++) read_port(`ZXUNO_DATA_PORT);

      // Unmapped register and foreign ports
      write_port(`ZXUNO_ADDR_PORT, 8'h7A);
      read_port(`ZXUNO_DATA_PORT);
      for (k = 0; k < 4; k++) read_port(other_port());

      random_mix(n_random);

      // Interrupts
      write_port(`ZXUNO_ADDR_PORT, `REG_RASTERCTRL);
      write_port(`ZXUNO_DATA_PORT, 8'h00);
      check_int_frame(`INT_LEN, 0);
      line = 9'($urandom_range(1, `V_TOTAL - 1));
      write_port(`ZXUNO_ADDR_PORT, `REG_RASTERLINE);
      write_port(`ZXUNO_DATA_PORT, line[7:0]);
      write_port(`ZXUNO_ADDR_PORT, `REG_RASTERCTRL);
      write_port(`ZXUNO_DATA_PORT, {6'b000000, 1'b1, line[8]});
      check_int_frame(2 * `INT_LEN, `INT_LEN);
      write_port(`ZXUNO_DATA_PORT, 8'h04);
      check_int_frame(0, 0);

      $display("Testbench passed");
      $finish;
   end

endmodule

// File: rtl/zxuno_top.sv
`timescale 1ns/1ps
`include "zxuno_params.svh"

module zxuno_top import zxuno_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  cpudout,
   output logic [7:0]  cpudin,
   output logic        int_n,
   output logic        disable_ay,
   output logic        disable_turboay,
   output logic        disable_7ffd,
   output logic        disable_1ffd,
   output logic        disable_romsel7f,
   output logic        disable_romsel1f,
   output logic        enable_timexmmu,
   output logic        disable_spisd
);

   logic [7:0] addr_dout;
   logic       addr_oe;
   logic [7:0] reg_dout;
   logic       reg_oe;
   logic       data_rd;
   devopt_u    devoptions;
   logic [8:0] raster_line;
   logic       rasterint_enable;
   logic       vretraceint_disable;
   logic       raster_int_in_progress;

   zxuno_reg_if reg_bus ();

   zxuno_port_fsm port_fsm_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .iorq_n    (iorq_n),
      .rd_n      (rd_n),
      .wr_n      (wr_n),
      .cpudout   (cpudout),
      .reg_bus   (reg_bus.host),
      .addr_dout (addr_dout),
      .addr_oe   (addr_oe)
   );

   zxuno_regs regs_i (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .reg_bus                (reg_bus.dev),
      .raster_int_in_progress (raster_int_in_progress),
      .devoptions             (devoptions),
      .raster_line            (raster_line),
      .rasterint_enable       (rasterint_enable),
      .vretraceint_disable    (vretraceint_disable),
      .reg_dout               (reg_dout),
      .reg_oe                 (reg_oe)
   );

   raster_timer timer_i (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .raster_line            (raster_line),
      .rasterint_enable       (rasterint_enable),
      .vretraceint_disable    (vretraceint_disable),
      .int_n                  (int_n),
      .raster_int_in_progress (raster_int_in_progress)
   );

   // ----------------------------------------------------------
   // CPU data-in priority mux
   // ----------------------------------------------------------
   assign data_rd = !iorq_n && !rd_n && (a == `ZXUNO_DATA_PORT);

   // Unmapped registers read 0, other ports see the floating bus
   always_comb begin
      if (addr_oe) begin
         cpudin = addr_dout;
      end else if (data_rd) begin
         cpudin = reg_oe ? reg_dout : 8'h00;
      end else begin
         cpudin = 8'hFF;
      end
   end

   assign disable_ay       = devoptions.flags.disable_ay;
   assign disable_turboay  = devoptions.flags.disable_turboay;
   assign disable_7ffd     = devoptions.flags.disable_7ffd;
   assign disable_1ffd     = devoptions.flags.disable_1ffd;
   assign disable_romsel7f = devoptions.flags.disable_romsel7f;
   assign disable_romsel1f = devoptions.flags.disable_romsel1f;
   assign enable_timexmmu  = devoptions.flags.enable_timexmmu;
   assign disable_spisd    = devoptions.flags.disable_spisd;

endmodule

// File: rtl/zxuno_regs.sv
`timescale 1ns/1ps
`include "zxuno_params.svh"

module zxuno_regs import zxuno_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   zxuno_reg_if.dev   reg_bus,
   input  logic       raster_int_in_progress,
   output devopt_u    devoptions,
   output logic [8:0] raster_line,
   output logic       rasterint_enable,
   output logic       vretraceint_disable,
   output logic [7:0] reg_dout,
   output logic       reg_oe
);

   localparam int idx_w = $clog2(`COREID_LEN);
   localparam logic [8*`COREID_LEN-1:0] coreid_str = `COREID_TEXT;
   localparam logic [idx_w-1:0] idx_last = idx_w'(`COREID_LEN - 1);

   logic [7:0]       scratch;
   logic [idx_w-1:0] coreid_idx;
   logic [7:0]       coreid_char;

   // ----------------------------------------------------------
   // Writable registers
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scratch             <= '0;
         devoptions.raw      <= '0;
         raster_line         <= '0;
         rasterint_enable    <= 1'b0;
         vretraceint_disable <= 1'b0;
      end else if (reg_bus.regwr) begin
         case (reg_bus.addr)
            `REG_SCRATCH: begin
               scratch <= reg_bus.wdata;
            end
            `REG_RASTERLINE: begin
               raster_line[7:0] <= reg_bus.wdata;
            end
            `REG_RASTERCTRL: begin
               // Line bit 8 lives in the control register
               raster_line[8]      <= reg_bus.wdata[0];
               rasterint_enable    <= reg_bus.wdata[1];
               vretraceint_disable <= reg_bus.wdata[2];
            end
            `REG_DEVOPTIONS: begin
               devoptions.raw <= reg_bus.wdata;
            end
            default: begin
            end
         endcase
      end
   end

   // ----------------------------------------------------------
   // Core id, one character per read
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         coreid_idx <= '0;
      end else if (reg_bus.regaddr_changed) begin
         // Any new register selection restarts the string
         coreid_idx <= '0;
      end else if (reg_bus.regrd && reg_bus.addr == `REG_COREID) begin
         if (coreid_idx == idx_last) begin
            coreid_idx <= '0;
         end else begin
            coreid_idx <= coreid_idx + 1'b1;
         end
      end
   end

   // First character sits in the top byte of the literal
   assign coreid_char = coreid_str[8*(idx_last - coreid_idx) +: 8];

   // ----------------------------------------------------------
   // Read mux
   // ----------------------------------------------------------
   always_comb begin
      reg_oe = 1'b1;
      case (reg_bus.addr)
         `REG_SCRATCH:    reg_dout = scratch;
         `REG_RASTERLINE: reg_dout = raster_line[7:0];
         `REG_RASTERCTRL: reg_dout = {raster_int_in_progress, 4'b0000,
                                      vretraceint_disable, rasterint_enable,
                                      raster_line[8]};
         `REG_DEVOPTIONS: reg_dout = devoptions.raw;
         `REG_COREID:     reg_dout = coreid_char;
         default: begin
            reg_dout = 8'h00;
            reg_oe   = 1'b0;
         end
      endcase
   end

endmodule

// File: rtl/raster_timer.sv
`timescale 1ns/1ps
`include "zxuno_params.svh"

module raster_timer (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [8:0] raster_line,
   input  logic       rasterint_enable,
   input  logic       vretraceint_disable,
   output logic       int_n,
   output logic       raster_int_in_progress
);

   localparam logic [8:0] h_last  = 9'(`H_TOTAL - 1);
   localparam logic [8:0] v_last  = 9'(`V_TOTAL - 1);
   localparam logic [8:0] int_end = 9'(`INT_LEN);
   localparam logic [8:0] v_total = 9'(`V_TOTAL);

   logic [8:0] hcount;
   logic [8:0] vcount;
   logic       in_pulse;
   logic       vretrace_int;
   logic       raster_int;

   // ----------------------------------------------------------
   // Line and frame counters
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
      end else if (hcount == h_last) begin
         hcount <= '0;
         if (vcount == v_last) begin
            vcount <= '0;
         end else begin
            vcount <= vcount + 1'b1;
         end
      end else begin
         hcount <= hcount + 1'b1;
      end
   end

   // ----------------------------------------------------------
   // Interrupt sources
   // ----------------------------------------------------------
   assign in_pulse = (hcount < int_end);

   // Vertical retrace on line 0, on by default
   assign vretrace_int = !vretraceint_disable && (vcount == '0) && in_pulse;

   // Lines past the frame never match
   assign raster_int = rasterint_enable && (raster_line < v_total)
                       && (vcount == raster_line) && in_pulse;

   // Registered so int_n is clean and starts high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         int_n                  <= 1'b1;
         raster_int_in_progress <= 1'b0;
      end else begin
         int_n                  <= !(vretrace_int || raster_int);
         raster_int_in_progress <= raster_int;
      end
   end

   // Pulse always sits in the first INT_LEN clocks of a line
   a_int_window : assert property (@(posedge clk) disable iff (!rst_n)
      !int_n |-> $past(hcount) < int_end);

endmodule

// File: rtl/zxuno_port_fsm.sv
`timescale 1ns/1ps
`include "zxuno_params.svh"

module zxuno_port_fsm import zxuno_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  cpudout,
   zxuno_reg_if.host   reg_bus,
   output logic [7:0]  addr_dout,
   output logic        addr_oe
);

   localparam logic [1:0] st_idle   = 2'd0;
   localparam logic [1:0] st_strobe = 2'd1;
   localparam logic [1:0] st_hold   = 2'd2;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic       addr_hit;
   logic       data_hit;
   logic       io_rd;
   logic       io_wr;
   logic       access;
   logic       rd_kind;
   logic       wr_kind;
   logic       aw_kind;
   reg_addr_t  addr_q;
   logic [7:0] wdata_q;

   // ----------------------------------------------------------
   // Bus decode
   // ----------------------------------------------------------
   assign addr_hit = (a == `ZXUNO_ADDR_PORT);
   assign data_hit = (a == `ZXUNO_DATA_PORT);
   assign io_rd    = !iorq_n && !rd_n;
   assign io_wr    = !iorq_n && !wr_n;
   assign access   = (io_rd || io_wr) && (addr_hit || data_hit);

   // One strobe per I/O cycle, however long the CPU holds it
   always_comb begin
      case (state)
         st_idle: state_nxt = access ? st_strobe : st_idle;
         default: state_nxt = access ? st_hold : st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_idle;
         rd_kind <= 1'b0;
         wr_kind <= 1'b0;
         aw_kind <= 1'b0;
         addr_q  <= '0;
      end else begin
         state <= state_nxt;
         if (state == st_idle && access) begin
            // Write wins if both rd_n and wr_n are low
            rd_kind <= data_hit && io_rd && !io_wr;
            wr_kind <= data_hit && io_wr;
            aw_kind <= addr_hit && io_wr;
            if (addr_hit && io_wr) begin
               addr_q <= cpudout;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && access && data_hit && io_wr) begin
         wdata_q <= cpudout;
      end
   end

   // ----------------------------------------------------------
   // Register bus and address readback
   // ----------------------------------------------------------
   assign reg_bus.addr            = addr_q;
   assign reg_bus.wdata           = wdata_q;
   assign reg_bus.regrd           = (state == st_strobe) && rd_kind;
   assign reg_bus.regwr           = (state == st_strobe) && wr_kind;
   assign reg_bus.regaddr_changed = (state == st_strobe) && aw_kind;

   assign addr_dout = addr_q;
   assign addr_oe   = addr_hit && io_rd;

   a_strobe_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({reg_bus.regrd, reg_bus.regwr, reg_bus.regaddr_changed}));

   // A strobe only ever follows an access sampled in IDLE
   a_strobe_after_idle : assert property (@(posedge clk) disable iff (!rst_n)
      (reg_bus.regrd || reg_bus.regwr || reg_bus.regaddr_changed)
      |-> state != st_idle && $past(state == st_idle && access));

endmodule

// File: rtl/zxuno_reg_if.sv
`timescale 1ns/1ps

interface zxuno_reg_if import zxuno_pkg::*; ();

   reg_addr_t  addr;
   logic [7:0] wdata;
   logic       regrd;
   logic       regwr;
   logic       regaddr_changed;

   // Port decoder side
   modport host (output addr, output wdata, output regrd, output regwr,
                 output regaddr_changed);

   // Register bank side
   modport dev (input addr, input wdata, input regrd, input regwr,
                input regaddr_changed);

endinterface

// File: rtl/zxuno_pkg.sv
package zxuno_pkg;

   // Register number held in the address port
   typedef logic [7:0] reg_addr_t;

   // Device options byte
   // Written whole by the CPU, read bit by bit by the devices
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic disable_spisd;
         logic enable_timexmmu;
         logic disable_romsel1f;
         logic disable_romsel7f;
         logic disable_1ffd;
         logic disable_7ffd;
         logic disable_turboay;
         logic disable_ay;
      } flags;
   } devopt_u;

endpackage

// File: rtl/zxuno_params.svh
`ifndef ZXUNO_PARAMS_SVH
`define ZXUNO_PARAMS_SVH

// ----------------------------------------------------------
// I/O ports of the configuration register bank
// ----------------------------------------------------------
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// ----------------------------------------------------------
// Register numbers
// ----------------------------------------------------------
`define REG_SCRATCH    8'h03
`define REG_RASTERLINE 8'h0C
`define REG_RASTERCTRL 8'h0D
`define REG_DEVOPTIONS 8'h0E
`define REG_COREID     8'hFF

// ----------------------------------------------------------
// Video timing, in CPU clocks and lines
// ----------------------------------------------------------
`define H_TOTAL 448
`define V_TOTAL 312
`define INT_LEN 32

// Core identification, first character read first
`define COREID_LEN  8
`define COREID_TEXT "ZXCFG001"

`endif
